//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --timing -f files.f --top-module cacheTb -o cacheSim
	./obj_dir/cacheSim | tee /dev/stderr | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- files.f
+incdir+include
hdl/cacheAdrPkg.sv
hdl/cacheBusPkg.sv
hdl/cacheWay.sv
hdl/cacheLru.sv
hdl/cacheFsm.sv
hdl/cache.sv
test/cache_props.sv
test/cacheTb.sv

//--- hdl/cache.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache
  import cacheAdrPkg::*;
  import cacheBusPkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  cacheRwT             CacheRW,
  input  physAdrT             PAdr,
  input  byteMaskT            ByteMask,
  input  wordT                CacheWriteData,
  input  logic                FlushCache,
  input  logic                InvalidateCache,
  output wordT                ReadDataWord,
  output logic                CacheStall,
  output logic                CacheCommitted,
  output logic                CacheMiss,
  output logic                CacheAccess,
  output cacheRwT             CacheBusRW,
  output logic [`PA_BITS-1:0] CacheBusAdr,
  output lineT                CacheWriteLine,
  input  logic                CacheBusAck,
  input  lineT                FetchBuffer
);

  localparam int bytesPerWord = `WORDLEN/8;
  localparam int wordsPerLine = `LINELEN/`WORDLEN;

  setT                    cAdr;
  setT                    flushAdr;
  logic [1:0]             flushWay;
  logic [1:0]             hitWay;
  logic [1:0]             validWay;
  logic [1:0]             dirtyWay;
  logic [1:0]             victimWay;
  lineT                   readDataLineWay [2];
  tagT                    tagWay [2];
  lineT                   readDataLine;
  tagT                    tag;
  logic [wordIdxBits-1:0] wordIdx;
  lineMaskT               demuxedByteMask;
  lineMaskT               lineByteMask;
  lineMaskT               fetchBufferByteSel;
  lineT                   lineWriteData;
  physAdrT                missAdr;
  physAdrT                evictAdr;
  physAdrT                flushBusAdr;
  logic                   cacheHit;
  logic                   lineDirty;
  logic                   setValid;
  logic                   setDirty;
  logic                   clearDirty;
  logic                   selEvict;
  logic                   selFlush;
  logic                   selAdr;
  logic                   lruWriteEn;
  logic                   flushAdrCntEn;
  logic                   flushWayCntEn;
  logic                   flushAdrCntRst;
  logic                   flushWayCntRst;
  logic                   flushAdrFlag;
  logic                   flushWayFlag;

  //////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////

  // Index by the CPU address except while the flush walker runs
  assign cAdr = selAdr ? PAdr.fields.set : flushAdr;

  for (genvar w = 0; w < 2; w++) begin : wayGen
    cacheWay way (
      .clk, .reset, .CAdr(cAdr), .PAdr,
      .LineWriteData(lineWriteData), .LineByteMask(lineByteMask),
      .SetValid(setValid), .SetDirty(setDirty), .ClearDirty(clearDirty),
      .SelEvict(selEvict), .SelFlush(selFlush),
      .VictimWay(victimWay[w]), .FlushWay(flushWay[w]), .InvalidateCache,
      .ReadDataLineWay(readDataLineWay[w]), .TagWay(tagWay[w]),
      .HitWay(hitWay[w]), .ValidWay(validWay[w]), .DirtyWay(dirtyWay[w])
    );
  end

  cacheLru lru (
    .clk, .reset, .CAdr(cAdr), .HitWay(hitWay), .ValidWay(validWay),
    .LruWriteEn(lruWriteEn), .InvalidateCache, .VictimWay(victimWay)
  );

  // Each way already masked itself, so an OR finishes the way select
  assign readDataLine   = readDataLineWay[0] | readDataLineWay[1];
  assign tag            = tagWay[0] | tagWay[1];
  assign cacheHit       = |hitWay;
  assign lineDirty      = |dirtyWay;
  assign CacheWriteLine = readDataLine;

  assign wordIdx      = PAdr.fields.offset[offsetBits-1:byteOffBits];
  assign ReadDataWord = readDataLine[wordIdx*`WORDLEN +: `WORDLEN];

  //////////////////////////////////////////////////
  // Write path
  //////////////////////////////////////////////////

  // Place the word's byte mask at the addressed word of the line
  always_comb begin
    for (int w = 0; w < wordsPerLine; w++) begin
      demuxedByteMask[w*bytesPerWord +: bytesPerWord] = (wordIdx == w) ? ByteMask : '0;
    end
  end

  // A fill takes every byte from the bus, a write hit only the masked CPU bytes
  assign fetchBufferByteSel = setValid ? '1 : ~demuxedByteMask;
  assign lineByteMask       = setValid ? '1 : (setDirty ? demuxedByteMask : '0);

  always_comb begin
    for (int i = 0; i < `LINELEN/8; i++) begin
      lineWriteData[8*i +: 8] = fetchBufferByteSel[i]
                              ? FetchBuffer[8*i +: 8]
                              : CacheWriteData[8*(i % bytesPerWord) +: 8];
    end
  end

  // Line aligned bus address from the miss, the victim or the flush walker
  always_comb begin
    missAdr                   = PAdr;
    missAdr.fields.offset     = '0;
    evictAdr                  = missAdr;
    evictAdr.fields.tag       = tag;
    flushBusAdr               = evictAdr;
    flushBusAdr.fields.set    = flushAdr;
    if (selFlush) begin
      CacheBusAdr = flushBusAdr.raw;
    end else if (selEvict) begin
      CacheBusAdr = evictAdr.raw;
    end else begin
      CacheBusAdr = missAdr.raw;
    end
  end

  //////////////////////////////////////////////////
  // Flush walker
  //////////////////////////////////////////////////

  // Way advances first, the set steps when the last way wraps
  always_ff @(posedge clk) begin
    if (reset | flushAdrCntRst) begin
      flushAdr <= '0;
    end else if (flushAdrCntEn) begin
      flushAdr <= flushAdr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset | flushWayCntRst) begin
      flushWay <= 2'b01;
    end else if (flushWayCntEn) begin
      flushWay <= {flushWay[0], flushWay[1]};
    end
  end

  assign flushAdrFlag = (flushAdr == setT'(`NUMLINES - 1));
  assign flushWayFlag = flushWay[1];

  cacheFsm fsm (
    .clk, .reset, .CacheRW, .FlushCache, .InvalidateCache,
    .CacheHit(cacheHit), .LineDirty(lineDirty), .CacheBusAck,
    .FlushAdrFlag(flushAdrFlag), .FlushWayFlag(flushWayFlag),
    .CacheStall, .CacheCommitted, .CacheMiss, .CacheAccess, .CacheBusRW,
    .SetValid(setValid), .SetDirty(setDirty), .ClearDirty(clearDirty),
    .SelEvict(selEvict), .SelFlush(selFlush), .SelAdr(selAdr),
    .LruWriteEn(lruWriteEn), .FlushAdrCntEn(flushAdrCntEn),
    .FlushWayCntEn(flushWayCntEn), .FlushAdrCntRst(flushAdrCntRst),
    .FlushWayCntRst(flushWayCntRst)
  );

endmodule

//--- hdl/cacheAdrPkg.sv
`include "cache_settings.svh"

package cacheAdrPkg;

  // Field widths of the physical address
  localparam int offsetBits  = $clog2(`LINELEN/8);
  localparam int setBits     = $clog2(`NUMLINES);
  localparam int tagBits     = `PA_BITS - setBits - offsetBits;

  // Byte position inside a word and word position inside a line
  localparam int byteOffBits = $clog2(`WORDLEN/8);
  localparam int wordIdxBits = offsetBits - byteOffBits;

  typedef logic [tagBits-1:0]      tagT;
  typedef logic [setBits-1:0]      setT;
  typedef logic [offsetBits-1:0]   offsetT;
  typedef logic [`LINELEN-1:0]     lineT;
  typedef logic [`WORDLEN-1:0]     wordT;
  typedef logic [`WORDLEN/8-1:0]   byteMaskT;
  typedef logic [`LINELEN/8-1:0]   lineMaskT;

  // Indexing view, tag in the upper bits and byte offset at the bottom
  typedef struct packed {
    tagT    tag;
    setT    set;
    offsetT offset;
  } adrFieldsT;

  // The same address word seen raw on the bus or split for lookup
  typedef union packed {
    logic [`PA_BITS-1:0] raw;
    adrFieldsT           fields;
  } physAdrT;

endpackage

//--- hdl/cacheBusPkg.sv
package cacheBusPkg;

  // Request encoding shared by the CPU side and the bus side
  // Bit 1 marks a read and bit 0 marks a write
  typedef enum logic [1:0] {
    rwNone  = 2'b00,
    rwWrite = 2'b01,
    rwRead  = 2'b10
  } cacheRwT;

  // On the bus side a write carries the victim line out on CacheWriteLine
  // A read brings a whole line back on FetchBuffer in the acknowledge cycle
  // Either request stays on the bus until that acknowledge

  // On the CPU side a write merges the masked bytes of one word into the line
  // and a read returns the addressed word of the line

endpackage

//--- hdl/cacheFsm.sv
`timescale 1ns/1ps

module cacheFsm
  import cacheBusPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  cacheRwT CacheRW,
  input  logic    FlushCache,
  input  logic    InvalidateCache,
  input  logic    CacheHit,
  input  logic    LineDirty,
  input  logic    CacheBusAck,
  input  logic    FlushAdrFlag,
  input  logic    FlushWayFlag,
  output logic    CacheStall,
  output logic    CacheCommitted,
  output logic    CacheMiss,
  output logic    CacheAccess,
  output cacheRwT CacheBusRW,
  output logic    SetValid,
  output logic    SetDirty,
  output logic    ClearDirty,
  output logic    SelEvict,
  output logic    SelFlush,
  output logic    SelAdr,
  output logic    LruWriteEn,
  output logic    FlushAdrCntEn,
  output logic    FlushWayCntEn,
  output logic    FlushAdrCntRst,
  output logic    FlushWayCntRst
);

  typedef enum logic [2:0] {
    ready,
    writeBack,
    fetch,
    fillWrite,
    flushCheck,
    flushWriteBack,
    flushIncr
  } stateT;

  stateT state;
  stateT nextState;
  logic  cpuReq;
  logic  readyHit;
  logic  readyMiss;
  logic  flushStart;
  logic  flushDone;

  //////////////////////////////////////////////////
  // Decisions taken in the ready state
  //////////////////////////////////////////////////

  assign cpuReq = (CacheRW != rwNone);

  // A request that meets an invalidate waits one cycle and is looked up again
  assign readyHit   = (state == ready) & cpuReq & ~InvalidateCache & CacheHit;
  assign readyMiss  = (state == ready) & cpuReq & ~InvalidateCache & ~CacheHit;
  assign flushStart = (state == ready) & ~cpuReq & FlushCache;
  assign flushDone  = FlushAdrFlag & FlushWayFlag;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ready;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      ready: begin
        // The victim is already selected here, so LineDirty is its dirty bit
        if (readyMiss) begin
          nextState = LineDirty ? writeBack : fetch;
        end else if (flushStart) begin
          nextState = flushCheck;
        end
      end
      writeBack:      if (CacheBusAck) nextState = fetch;
      fetch:          if (CacheBusAck) nextState = fillWrite;
      // Return to ready so the request is looked up again and hits
      fillWrite:      nextState = ready;
      flushCheck:     nextState = LineDirty ? flushWriteBack : flushIncr;
      flushWriteBack: if (CacheBusAck) nextState = flushIncr;
      flushIncr:      nextState = flushDone ? ready : flushCheck;
      default:        nextState = ready;
    endcase
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  // Only a completed hit lets the CPU move on
  assign CacheStall     = (state != ready) | (cpuReq & ~readyHit) | flushStart;
  assign CacheCommitted = (state == writeBack) | (state == fetch) | (state == fillWrite);
  assign CacheMiss      = readyMiss;
  assign CacheAccess    = readyHit;
  assign LruWriteEn     = readyHit;
  assign SetDirty       = readyHit & (CacheRW == rwWrite);

  // FetchBuffer is only valid in the acknowledge cycle, so the fill lands then
  assign SetValid   = (state == fetch) & CacheBusAck;
  assign ClearDirty = (state == flushWriteBack) & CacheBusAck;
  assign SelEvict   = readyMiss | (state == writeBack);
  assign SelFlush   = (state == flushCheck) | (state == flushWriteBack) | (state == flushIncr);
  assign SelAdr     = ~SelFlush;

  // The walker restarts from set 0, way 0 whenever the FSM sits in ready
  assign FlushAdrCntRst = (state == ready);
  assign FlushWayCntRst = (state == ready);
  assign FlushWayCntEn  = (state == flushIncr) & ~flushDone;
  assign FlushAdrCntEn  = FlushWayCntEn & FlushWayFlag;

  always_comb begin
    case (state)
      writeBack,
      flushWriteBack: CacheBusRW = rwWrite;
      fetch:          CacheBusRW = rwRead;
      default:        CacheBusRW = rwNone;
    endcase
  end

endmodule

//--- hdl/cacheLru.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cacheLru
  import cacheAdrPkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  setT        CAdr,
  input  logic [1:0] HitWay,
  input  logic [1:0] ValidWay,
  input  logic       LruWriteEn,
  input  logic       InvalidateCache,
  output logic [1:0] VictimWay
);

  // One bit per set, high when way 1 was the most recent user
  logic [`NUMLINES-1:0] mruBits;

  // Empty ways are filled before anything gets evicted
  // With both ways valid the victim is the one not used last
  always_comb begin
    if (!ValidWay[0]) begin
      VictimWay = 2'b01;
    end else if (!ValidWay[1]) begin
      VictimWay = 2'b10;
    end else if (mruBits[CAdr]) begin
      VictimWay = 2'b01;
    end else begin
      VictimWay = 2'b10;
    end
  end

  // Only a real hit moves the set's history
  always_ff @(posedge clk) begin
    if (reset | InvalidateCache) begin
      mruBits <= '0;
    end else if (LruWriteEn & (|HitWay)) begin
      mruBits[CAdr] <= HitWay[1];
    end
  end

endmodule

//--- hdl/cacheWay.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cacheWay
  import cacheAdrPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  setT      CAdr,
  input  physAdrT  PAdr,
  input  lineT     LineWriteData,
  input  lineMaskT LineByteMask,
  input  logic     SetValid,
  input  logic     SetDirty,
  input  logic     ClearDirty,
  input  logic     SelEvict,
  input  logic     SelFlush,
  input  logic     VictimWay,
  input  logic     FlushWay,
  input  logic     InvalidateCache,
  output lineT     ReadDataLineWay,
  output tagT      TagWay,
  output logic     HitWay,
  output logic     ValidWay,
  output logic     DirtyWay
);

  // Storage for one way, indexed by set
  tagT                  tagMem [`NUMLINES];
  lineT                 dataMem [`NUMLINES];
  logic [`NUMLINES-1:0] validBits;
  logic [`NUMLINES-1:0] dirtyBits;
  logic                 selectedWay;

  //////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////

  assign ValidWay = validBits[CAdr];
  assign HitWay   = ValidWay & (tagMem[CAdr] == PAdr.fields.tag);

  // The flush walker owns the way during a flush
  // Eviction and fill go to the victim, a write hit goes to the hit way
  assign selectedWay = SelFlush ? FlushWay
                     : ((SelEvict | SetValid) ? VictimWay : HitWay);

  // Unselected ways drive zeros so the top level can OR them together
  assign ReadDataLineWay = selectedWay ? dataMem[CAdr] : '0;
  assign TagWay          = selectedWay ? tagMem[CAdr] : '0;
  // An invalid line never counts as dirty even if its old bit is still set
  assign DirtyWay        = selectedWay & ValidWay & dirtyBits[CAdr];

  //////////////////////////////////////////////////
  // Update
  //////////////////////////////////////////////////

  // Fill writes the whole line, a write hit only the bytes under the mask
  always_ff @(posedge clk) begin
    if (selectedWay & (SetValid | SetDirty)) begin
      for (int i = 0; i < `LINELEN/8; i++) begin
        if (LineByteMask[i]) begin
          dataMem[CAdr][8*i +: 8] <= LineWriteData[8*i +: 8];
        end
      end
    end
    if (selectedWay & SetValid) begin
      tagMem[CAdr] <= PAdr.fields.tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else begin
      // Invalidate wipes every set of this way in one edge
      if (InvalidateCache) begin
        validBits <= '0;
      end else if (selectedWay & SetValid) begin
        validBits[CAdr] <= 1'b1;
      end
      // A freshly filled line starts clean, flush write-back cleans it too
      if (selectedWay & (SetValid | ClearDirty)) begin
        dirtyBits[CAdr] <= 1'b0;
      end else if (selectedWay & SetDirty) begin
        dirtyBits[CAdr] <= 1'b1;
      end
    end
  end

endmodule

//--- include/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

//////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////

// Physical address width in bits, covering a 64 KiB space
`define PA_BITS 16

// One cache line in bits, which is also one bus transfer
`define LINELEN 128

// CPU word width in bits
`define WORDLEN 32

// Sets per way, each way holds this many lines
`define NUMLINES 8

// The tag, set and offset widths follow from these four values
// and live with the types that use them
// With the numbers above a line is 16 bytes, so the offset is 4 bits,
// the set index is 3 bits and the tag keeps the upper 9 bits

`endif

//--- test/cacheTb.sv
`timescale 1ns/1ps

module cacheTb
  import cacheAdrPkg::*;
  import cacheBusPkg::*;
();

  localparam int opRead  = 0;
  localparam int opWrite = 1;
  localparam int opFlush = 2;
  localparam int opInval = 3;

  logic     clk;
  logic     reset;
  cacheRwT  CacheRW;
  physAdrT  PAdr;
  byteMaskT ByteMask;
  wordT     CacheWriteData;
  logic     FlushCache;
  logic     InvalidateCache;
  wordT     ReadDataWord;
  logic     CacheStall;
  logic     CacheCommitted;
  logic     CacheMiss;
  logic     CacheAccess;
  cacheRwT  CacheBusRW;
  logic [15:0] CacheBusAdr;
  lineT     CacheWriteLine;
  logic     CacheBusAck;
  lineT     FetchBuffer;

  // Bus side memory and the CPU-visible reference memory hold one byte per entry
  logic [7:0]  busMem [65536];
  logic [7:0]  refMem [65536];
  // Expected cache state covers two ways by eight sets
  logic [8:0]  refTag [2][8];
  logic        refValid [2][8];
  logic        refMru [8];
  logic [31:0] rngState;
  int          busWait;
  int          missCount;
  int          accessCount;
  int          expMiss;
  int          expAccess;
  // Stimulus table columns
  int          opKind [$];
  logic [15:0] opAdr [$];
  logic [3:0]  opMask [$];
  logic [31:0] opData [$];
  logic [31:0] opExp [$];

  cache i_cache (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic failRun();
    $display("Checks failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic expectLow(input string name, input logic v);
    assert (v == 1'b0) else begin
      $display("error at %0t: %s is %b, expected 0", $time, name, v);
      failRun();
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Little-endian word from the reference memory
  function automatic logic [31:0] refWord(input logic [15:0] a);
    return {refMem[a + 16'd3], refMem[a + 16'd2], refMem[a + 16'd1], refMem[a]};
  endfunction

  task automatic addOp(input int k, input logic [15:0] a, input logic [3:0] m,
                       input logic [31:0] d, input logic [31:0] e);
    opKind.push_back(k);
    opAdr.push_back(a);
    opMask.push_back(m);
    opData.push_back(d);
    opExp.push_back(e);
  endtask

  // Predicts hit or miss, then fills and marks the used way most recent
  task automatic predictAccess(input logic [15:0] a, output logic hit);
    int way;
    int s;
    s = int'(a[6:4]);
    hit = 1'b0;
    way = 0;
    for (int w = 0; w < 2; w++) begin
      if (refValid[w][s] && refTag[w][s] == a[15:7]) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      // Empty way first, else the one not used last
      if (!refValid[0][s]) way = 0;
      else if (!refValid[1][s]) way = 1;
      else way = refMru[s] ? 0 : 1;
      refValid[way][s] = 1'b1;
      refTag[way][s] = a[15:7];
      expMiss++;
    end
    refMru[s] = (way == 1);
    expAccess++;
  endtask

  //////////////////////////////////////////////////
  // Bus memory model
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (reset) begin
      CacheBusAck = 1'b0;
      busWait = -1;
    end else if (CacheBusAck) begin
      CacheBusAck = 1'b0;
      busWait = -1;
    end else if (CacheBusRW != rwNone) begin
      if (busWait < 0) begin
        rngState = xorshift(rngState);
        busWait = int'(rngState % 6);
      end
      if (busWait == 0) begin
        for (int i = 0; i < 16; i++) begin
          if (CacheBusRW == rwWrite) begin
            // A dirty victim carries exactly what the CPU last wrote
            assert (CacheWriteLine[8*i +: 8] == refMem[CacheBusAdr + 16'(i)]) else begin
              $display("error at %0t: CacheWriteLine byte %0d at %h is %h, expected %h",
                       $time, i, CacheBusAdr, CacheWriteLine[8*i +: 8],
                       refMem[CacheBusAdr + 16'(i)]);
              failRun();
            end
            busMem[CacheBusAdr + 16'(i)] = CacheWriteLine[8*i +: 8];
          end else begin
            FetchBuffer[8*i +: 8] = busMem[CacheBusAdr + 16'(i)];
          end
        end
        CacheBusAck = 1'b1;
      end else begin
        busWait--;
      end
    end
  end

  // Pulse counters sample before the edge updates the FSM
  always @(posedge clk) begin
    if (!reset) begin
      missCount   += int'(CacheMiss);
      accessCount += int'(CacheAccess);
    end
  end

  //////////////////////////////////////////////////
  // Operations
  //////////////////////////////////////////////////

  task automatic cpuAccess(input int k, input logic [15:0] a, input logic [3:0] m,
                           input logic [31:0] d, input logic [31:0] e);
    logic predHit;
    logic wbSeen;
    int   cycles;
    @(negedge clk);
    CacheRW = (k == opRead) ? rwRead : rwWrite;
    PAdr.raw = a;
    ByteMask = m;
    CacheWriteData = d;
    predictAccess(a, predHit);
    wbSeen = 1'b0;
    #25;
    // A hit completes in its first cycle, a miss must stall there
    assert (CacheStall == !predHit) else begin
      $display("error at %0t: CacheStall is %b, expected %b", $time, CacheStall, !predHit);
      failRun();
    end
    cycles = 0;
    while (CacheStall) begin
      @(negedge clk);
      #25;
      cycles++;
      if (cycles > 200) begin
        $display("Timeout: the cache kept stalling a request at %h", a);
        failRun();
      end
      // Once a victim goes out the miss stays committed until the fill is done
      if (CacheBusRW == rwWrite) begin
        wbSeen = 1'b1;
      end
      if (wbSeen && CacheStall) begin
        assert (CacheCommitted) else begin
          $display("error at %0t: CacheCommitted is %b, expected 1", $time, CacheCommitted);
          failRun();
        end
      end
    end
    expectLow("CacheCommitted", CacheCommitted);
    if (k == opRead) begin
      assert (ReadDataWord == e && e == refWord(a)) else begin
        $display("error at %0t: ReadDataWord is %h, expected %h", $time, ReadDataWord, e);
        failRun();
      end
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (m[b]) refMem[a + 16'(b)] = d[8*b +: 8];
      end
    end
    @(negedge clk);
    CacheRW = rwNone;
  endtask

  task automatic flushAndCompare();
    int cycles;
    @(negedge clk);
    FlushCache = 1'b1;
    #25;
    assert (CacheStall) else begin
      $display("The cache did not stall when a flush was started");
      failRun();
    end
    @(negedge clk);
    FlushCache = 1'b0;
    cycles = 0;
    #25;
    while (CacheStall) begin
      @(negedge clk);
      #25;
      cycles++;
      if (cycles > 2000) begin
        $display("Timeout: the flush did not finish");
        failRun();
      end
    end
    // Every dirty line is now back in the bus memory
    for (int i = 0; i < 65536; i++) begin
      assert (busMem[i] == refMem[i]) else begin
        $display("error at %0t: busMem[%h] is %h, expected %h", $time, i, busMem[i], refMem[i]);
        failRun();
      end
    end
  endtask

  task automatic invalidateAll();
    @(negedge clk);
    InvalidateCache = 1'b1;
    #25;
    assert (!CacheStall) else begin
      $display("The cache stalled on an invalidate");
      failRun();
    end
    @(negedge clk);
    InvalidateCache = 1'b0;
    for (int s = 0; s < 8; s++) begin
      refValid[0][s] = 1'b0;
      refValid[1][s] = 1'b0;
      refMru[s] = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus table and main sequence
  //////////////////////////////////////////////////

  initial begin
    CacheRW = rwNone;
    PAdr = '0;
    ByteMask = '0;
    CacheWriteData = '0;
    FlushCache = 1'b0;
    InvalidateCache = 1'b0;
    CacheBusAck = 1'b0;
    FetchBuffer = '0;
    rngState = 32'd5390;
    busWait = -1;
    missCount = 0;
    accessCount = 0;
    expMiss = 0;
    expAccess = 0;
    // Fill pattern mixes both address bytes
    for (int i = 0; i < 65536; i++) begin
      busMem[i] = 8'(i) ^ 8'(i >> 8);
      refMem[i] = 8'(i) ^ 8'(i >> 8);
    end
    for (int s = 0; s < 8; s++) begin
      refValid[0][s] = 1'b0;
      refValid[1][s] = 1'b0;
      refTag[0][s] = '0;
      refTag[1][s] = '0;
      refMru[s] = 1'b0;
    end
    // Read miss then hit, masked write, three tags in set 0
    addOp(opRead,  16'h0100, 4'b0000, 32'h0, 32'h02030001);
    addOp(opRead,  16'h0104, 4'b0000, 32'h0, 32'h06070405);
    addOp(opWrite, 16'h0100, 4'b0101, 32'hAABBCCDD, 32'h0);
    addOp(opRead,  16'h0100, 4'b0000, 32'h0, 32'h02BB00DD);
    addOp(opRead,  16'h0200, 4'b0000, 32'h0, 32'h01000302);
    addOp(opRead,  16'h0300, 4'b0000, 32'h0, 32'h00010203);
    addOp(opRead,  16'h0100, 4'b0000, 32'h0, 32'h02BB00DD);
    addOp(opWrite, 16'h0308, 4'b1111, 32'h11223344, 32'h0);
    addOp(opWrite, 16'h0234, 4'b1000, 32'h99000000, 32'h0);
    addOp(opFlush, 16'h0000, 4'b0000, 32'h0, 32'h0);
    addOp(opRead,  16'h0308, 4'b0000, 32'h0, 32'h11223344);
    addOp(opRead,  16'h0234, 4'b0000, 32'h0, 32'h99343736);
    addOp(opInval, 16'h0000, 4'b0000, 32'h0, 32'h0);
    addOp(opRead,  16'h0308, 4'b0000, 32'h0, 32'h11223344);
    addOp(opRead,  16'h0100, 4'b0000, 32'h0, 32'h02BB00DD);
    addOp(opWrite, 16'h0104, 4'b1111, 32'hCAFEF00D, 32'h0);
    addOp(opRead,  16'h0104, 4'b0000, 32'h0, 32'hCAFEF00D);
    addOp(opFlush, 16'h0000, 4'b0000, 32'h0, 32'h0);
    reset = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    #25;
    // Out of reset the cache is idle
    expectLow("CacheStall", CacheStall);
    expectLow("CacheCommitted", CacheCommitted);
    expectLow("CacheMiss", CacheMiss);
    expectLow("CacheAccess", CacheAccess);
    for (int n = 0; n < opKind.size(); n++) begin
      case (opKind[n])
        opFlush: flushAndCompare();
        opInval: invalidateAll();
        default: cpuAccess(opKind[n], opAdr[n], opMask[n], opData[n], opExp[n]);
      endcase
    end
    repeat (2) @(negedge clk);
    assert (missCount == expMiss) else begin
      $display("error at %0t: CacheMiss count is %0d, expected %0d", $time, missCount, expMiss);
      failRun();
    end
    assert (accessCount == expAccess) else begin
      $display("error at %0t: CacheAccess count is %0d, expected %0d",
               $time, accessCount, expAccess);
      failRun();
    end
    $display("All checks passed");
    $finish;
  end

endmodule

//--- test/cache_props.sv
`timescale 1ns/1ps

module cacheProps
  import cacheBusPkg::*;
(
  input logic    clk,
  input logic    reset,
  input cacheRwT CacheRW,
  input logic    FlushCache,
  input cacheRwT CacheBusRW,
  input logic    CacheBusAck,
  input logic    CacheMiss
);

  // High once the CPU has asked for anything since reset
  logic cpuSeen;

  always_ff @(posedge clk) begin
    if (reset) begin
      cpuSeen <= 1'b0;
    end else if (CacheRW != rwNone || FlushCache) begin
      cpuSeen <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // FSM protocol
  //////////////////////////////////////////////////

  busHold: assert property (@(posedge clk) disable iff (reset)
    (CacheBusRW != rwNone && !CacheBusAck) |=> (CacheBusRW == $past(CacheBusRW)))
    else $error("bus request changed before its acknowledge");

  // A miss is counted once per request
  missPulse: assert property (@(posedge clk) disable iff (reset)
    CacheMiss |=> !CacheMiss)
    else $error("CacheMiss stayed high for more than one cycle");

  quietBus: assert property (@(posedge clk) disable iff (reset)
    !cpuSeen |-> (CacheBusRW == rwNone))
    else $error("bus request issued before any CPU request");

endmodule

bind cacheFsm cacheProps fsmProps (
  .clk, .reset, .CacheRW, .FlushCache, .CacheBusRW, .CacheBusAck, .CacheMiss
);
